/* files.f */
source/i2cPkg.sv
source/i2cCsr.sv
source/i2cBitEngine.sv
source/i2cKeypadSeq.sv
source/i2cKeypadTop.sv
sim/i2cKeypadSva.sv
sim/i2cKeypadTb.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run, then look for the pass line in the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f files.f --top-module i2cKeypadTb -o simv \
	&& ./obj_dir/simv > sim.log 2>&1 \
	|| echo "Build or run returned an error"
cat sim.log 2>/dev/null
grep -qx "test passed" sim.log 2>/dev/null && echo "PASS" || { echo "FAIL"; exit 1; }
exit 0

/* sim/i2cKeypadSva.sv */
// Bus and pin assertions
`timescale 1ns/1ps
`default_nettype none

module i2cKeypadSva (
	input wire			iSysClk,
	input wire			rst,
	input wire [1:0]	engSt,		// Engine state or zero where unused
	input wire			sclOe,
	input wire			sdaOe,
	input wire			blockHit,
	input wire			rEd
);
	localparam logic [1:0] stByte = 2'd3;	// Byte state encoding in the engine

	// Data line only moves while SCL is held low
	aSdaStable: assert property (@(posedge iSysClk) disable iff (rst)
		(engSt == stByte && $past(engSt) == stByte && !sclOe && !$past(sclOe))
		|-> (sdaOe == $past(sdaOe)))
		else $error("SDA changed while SCL high inside a byte");

	aReadValid: assert property (@(posedge iSysClk) disable iff (rst)
		blockHit |=> rEd)
		else $error("Block hit without read valid one cycle later");

	// Bus released all through reset
	aRstRelease: assert property (@(posedge iSysClk)
		(rst && $past(rst)) |-> (!sclOe && !sdaOe))
		else $error("I2C lines driven during reset");

endmodule

bind i2cBitEngine i2cKeypadSva engSva (
	.iSysClk(iSysClk), .rst(rst), .engSt(st), .sclOe(sclOe), .sdaOe(sdaOe),
	.blockHit(1'b0), .rEd(1'b0)
);

bind i2cCsr i2cKeypadSva csrSva (
	.iSysClk(iSysClk), .rst(rst), .engSt(2'd0), .sclOe(1'b0), .sdaOe(1'b0),
	.blockHit(usiWr.adrs[15:8] == pAdrsMap), .rEd(usiRd.rEd)
);

`default_nettype wire

/* sim/i2cKeypadTb.sv */
// Keypad poller testbench
`timescale 1ns/1ps
`default_nettype none

module i2cKeypadTb;
	import i2cPkg::*;

	localparam logic [7:0]	pAdrsMap	= 8'h04;
	localparam int			pI2CDivClk	= 16;
	localparam logic [6:0]	pKeypadAdrs	= 7'h27;
	localparam int			cycleLimit	= 40000;	// ~30 transactions plus margin

	// Slave states
	localparam int stIdle = 0;
	localparam int stAdrs = 1;
	localparam int stAAck = 2;
	localparam int stRead = 3;
	localparam int stRAck = 4;

	logic			iSysClk;
	logic			rst;
	usiWr_t			usiWr;
	usiRd_t			usiRd;
	logic			sclOe;
	logic			sdaOe;
	logic			slvOe = 1'b0;
	wire			scl;
	wire			sda;

	// Shadow registers and bookkeeping
	logic			shEn;
	logic [15:0]	shDiv;
	logic [15:0]	shKey;
	logic			shComp;
	logic			pendHit = 1'b0;
	logic [31:0]	pendData = 32'd0;
	int				errCnt = 0;
	int				chkCnt = 0;
	int				cycles = 0;

	// Slave model state
	logic [6:0]		slvAdrs;
	logic [15:0]	keyWord;
	logic [15:0]	txWord = 16'd0;
	logic [7:0]		rxShift = 8'd0;
	logic			prevScl = 1'b1;
	logic			prevSda = 1'b1;
	logic			mAck = 1'b0;
	logic			acked = 1'b0;
	logic			sawCond = 1'b0;
	logic			measure;
	int				slvSt = 0;
	int				bitCnt = 0;
	int				txPos = 0;
	int				highCnt = 0;
	int				pulses = 0;
	int				startCnt = 0;
	int				stopCnt = 0;
	int				doneCnt = 0;

	assign scl = ~sclOe;				// Pull-up without clock stretching
	assign sda = ~(sdaOe | slvOe);		// Wired AND of both drivers

	i2cKeypadTop #(
		.pAdrsMap	(pAdrsMap),
		.pI2CDivClk	(pI2CDivClk),
		.pKeypadAdrs(pKeypadAdrs)
	) i_dut (
		.iSysClk	(iSysClk),
		.rst		(rst),
		.usiWr		(usiWr),
		.usiRd		(usiRd),
		.sclOe		(sclOe),
		.sdaOe		(sdaOe),
		.sclIn		(scl),
		.sdaIn		(sda)
	);

	initial
		iSysClk = 1'b0;
	always #20 iSysClk = ~iSysClk;

	always @(posedge iSysClk)
	begin
		cycles <= cycles + 1;
		if (cycles >= cycleLimit)
		begin
			$display("Run stopped: no progress within %0d cycles", cycleLimit);
			$display("test failed");
			$finish;
		end
	end

	// ------------------------------
	// Reference model
	// ------------------------------
	function automatic logic [31:0] expRead(input logic [7:0] offset);
		case (offset)
			csrCtrl:	return {31'd0, shEn};
			csrDiv:		return {16'd0, shDiv};
			csrKeyPad:	return {16'd0, shKey};
			csrSeqComp:	return {31'd0, shComp};
			default:	return 32'd0;	// Hole in the map
		endcase
	endfunction

	// Compare at the falling edge against the request seen one edge earlier
	always @(negedge iSysClk)
	begin
		if (!rst)
		begin
			assert (usiRd.rEd == pendHit)
			else
			begin
				errCnt++;
				$display("Error: usiRd.rEd exp %h got %h", pendHit, usiRd.rEd);
			end
			if (pendHit)
			begin
				chkCnt++;
				assert (usiRd.rd == pendData)
				else
				begin
					errCnt++;
					$display("Error: usiRd.rd exp %h got %h", pendData, usiRd.rd);
				end
			end
		end
		pendHit  = (usiWr.adrs[15:8] == pAdrsMap);
		pendData = expRead(usiWr.adrs[7:0]);	// Value before this write lands
		if (pendHit && usiWr.wCke)
		begin
			if (usiWr.adrs[7:0] == csrCtrl)
				shEn = usiWr.wd[0];
			else if (usiWr.adrs[7:0] == csrDiv)
				shDiv = usiWr.wd[15:0];
		end
	end

	// ------------------------------
	// Keypad slave
	// ------------------------------
	always @(negedge iSysClk)
	begin
		if (scl && !prevScl)
		begin
			highCnt = 0;
			sawCond = 1'b0;
		end
		if (scl)
			highCnt++;
		if (scl && prevScl && prevSda && !sda)
		begin	// Start
			slvSt = stAdrs;
			bitCnt = 0;
			slvOe = 1'b0;
			sawCond = 1'b1;
			startCnt++;
		end
		else if (scl && prevScl && !prevSda && sda)
		begin	// Stop
			if (acked)
				doneCnt++;
			acked = 1'b0;
			slvSt = stIdle;
			slvOe = 1'b0;
			sawCond = 1'b1;
			stopCnt++;
		end
		else if (scl && !prevScl)
		begin	// Rising SCL
			if (slvSt == stAdrs)
			begin
				rxShift = {rxShift[6:0], sda};
				bitCnt++;
			end
			else if (slvSt == stRAck)
				mAck = !sda;
		end
		else if (!scl && prevScl)
		begin	// Falling SCL
			if (measure && !sawCond)
			begin
				pulses++;
				chkCnt++;
				assert (highCnt == 8)
				else
				begin
					errCnt++;
					$display("Error: SCL high cycles exp %h got %h", 8, highCnt);
				end
			end
			case (slvSt)
				stAdrs:
					if (bitCnt == 8)
					begin
						if (rxShift == {slvAdrs, 1'b1})
						begin
							slvSt = stAAck;
							slvOe = 1'b1;
							acked = 1'b1;
							txWord = keyWord;	// Word frozen per transaction
						end
						else
							slvSt = stIdle;
					end
				stAAck:
				begin
					slvSt = stRead;
					bitCnt = 0;
					txPos = 0;
					slvOe = !txWord[15];
				end
				stRead:
				begin
					bitCnt++;
					txPos++;
					if (bitCnt == 8)
					begin
						slvSt = stRAck;
						slvOe = 1'b0;
					end
					else
						slvOe = !txWord[15 - txPos];
				end
				stRAck:
					if (mAck && txPos < 16)
					begin
						slvSt = stRead;
						bitCnt = 0;
						slvOe = !txWord[15 - txPos];
					end
					else
					begin
						slvSt = stIdle;
						slvOe = 1'b0;
					end
				default:
				begin
				end
			endcase
		end
		prevScl = scl;
		prevSda = sda;
	end

	// ------------------------------
	// Bus tasks
	// ------------------------------
	task automatic busWrite(input logic [31:0] adrs, input logic [31:0] wd);
		@(posedge iSysClk);
		usiWr <= '{adrs: adrs, wd: wd, wCke: 1'b1};
		@(posedge iSysClk);
		usiWr <= '0;
	endtask

	task automatic busRead(input logic [31:0] adrs);
		@(posedge iSysClk);
		usiWr <= '{adrs: adrs, wd: 32'd0, wCke: 1'b0};
		@(posedge iSysClk);
		usiWr <= '0;
	endtask

	task automatic idle(input int n);
		repeat (n) @(posedge iSysClk);
	endtask

	task automatic report(input string name, input int errBefore);
		if (errCnt == errBefore)
			$display("Test %s: ok", name);
		else
			$display("Test %s: %0d mismatches", name, errCnt - errBefore);
	endtask

	initial
	begin
		int unsigned	seedVal;
		logic [31:0]	w;
		int				e0;
		int				c0;
		logic			driven;

		seedVal = $urandom(25);
		rst = 1'b1;
		usiWr = '0;
		shEn = 1'b0;
		shDiv = 16'hFFFF;
		shKey = 16'd0;
		shComp = 1'b0;
		slvAdrs = pKeypadAdrs;
		keyWord = 16'd0;
		measure = 1'b0;
		idle(8);
		rst <= 1'b0;
		idle(2);

		// 1 reset values and block decode
		e0 = errCnt;
		busRead(32'h0400);
		busRead(32'h0404);
		busRead(32'h0500);
		idle(3);
		report("reset values", e0);

		// 2 register write and read back with the divider first
		e0 = errCnt;
		repeat (4)
		begin
			w = $urandom();
			busWrite(32'h0404, w);
			busRead(32'h0404);
		end
		busWrite(32'h0404, ($urandom() & 32'hFFFF_0000) | 32'd3);
		busRead(32'h0404);
		repeat (4)
		begin
			w = $urandom() & 32'hFFFF_FFFE;
			busWrite(32'h0400, w);
			busRead(32'h0400);
		end
		busWrite(32'h0400, $urandom() | 32'd1);
		busRead(32'h0400);
		busWrite(32'h0400, 32'd0);
		busRead(32'h0400);
		busWrite(32'h0480, $urandom());
		busWrite(32'h0484, $urandom());
		busWrite(32'h0410, $urandom());
		busWrite(32'h0500, $urandom());
		busWrite(32'h0304, $urandom());
		busRead(32'h0400);
		busRead(32'h0404);
		busRead(32'h0480);
		busRead(32'h0484);
		busRead(32'h0410);
		idle(3);
		report("register access", e0);

		// 3 SCL high time at div 3
		e0 = errCnt;
		busWrite(32'h0400, 32'd1);
		measure = 1'b1;
		while (pulses < 54)
			@(posedge iSysClk);
		measure = 1'b0;
		report("scl timing", e0);

		// 4 key words through full transactions
		e0 = errCnt;
		repeat (4)
		begin
			keyWord = 16'($urandom());
			c0 = doneCnt;
			while (doneCnt < c0 + 2)
				@(posedge iSysClk);
			idle(30);
			shKey = keyWord;
			shComp = 1'b1;
			busRead(32'h0480);
			busRead(32'h0484);
		end
		idle(3);
		report("key polling", e0);

		// 5 no ack keeps the old key until disable
		e0 = errCnt;
		slvAdrs = pKeypadAdrs + 7'd1;
		c0 = startCnt;
		while (startCnt < c0 + 3)
			@(posedge iSysClk);
		busRead(32'h0480);
		busRead(32'h0484);
		c0 = startCnt;
		while (startCnt == c0)
			@(posedge iSysClk);
		busWrite(32'h0400, 32'd0);
		c0 = stopCnt;
		while (stopCnt == c0)
			@(posedge iSysClk);
		idle(20);
		c0 = startCnt;
		driven = 1'b0;
		repeat (1500)
		begin
			@(posedge iSysClk);
			if (sclOe || sdaOe)
				driven = 1'b1;
		end
		chkCnt++;
		assert (!driven && startCnt == c0)
		else
		begin
			errCnt++;
			$display("Bus was driven again after polling was disabled");
		end
		shComp = 1'b0;
		busRead(32'h0484);
		busRead(32'h0480);
		idle(3);
		report("nack and disable", e0);

		$display("Checks %0d, errors %0d", chkCnt, errCnt);
		if (errCnt == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

/* source/i2cBitEngine.sv */
// I2C byte level engine
`timescale 1ns/1ps
`default_nettype none

module i2cBitEngine #(
	parameter int	pI2CDivClk	= 16
)(
	input  wire						iSysClk,
	input  wire						rst,
	input  wire [pI2CDivClk-1:0]	div,		// Quarter bit = div+1 cycles
	input  wire i2cPkg::i2cCmd_t	cmd,
	input  wire						cmdValid,
	output logic					cmdReady,
	output i2cPkg::i2cRsp_t			rsp,
	output logic					rspValid,
	output logic					sclOe,		// 1 pulls SCL low
	output logic					sdaOe,		// 1 pulls SDA low
	input  wire						sclIn,
	input  wire						sdaIn
);
	import i2cPkg::*;

	typedef enum logic [1:0] {sIdle, sStart, sStop, sByte} engSt_t;

	engSt_t					st;
	logic [pI2CDivClk-1:0]	divLatch;	// Divider held for the whole command
	logic [pI2CDivClk-1:0]	qCnt;
	logic [1:0]				phase;		// Quarter within a bit
	logic [3:0]				bitCnt;		// 0..7 data, 8 ack
	logic					isRead;
	logic					ackBit;
	logic [7:0]				shift;
	logic					smpBit;
	logic					nackBit;
	logic					accept;
	logic					tick;
	logic					lastQ;
	logic					bitOe;
	logic					sclNext;
	logic					sdaNext;

	// One command in flight, ready returns after the response pulse
	assign cmdReady = (st == sIdle) & ~rspValid;
	assign accept   = cmdValid & cmdReady;
	assign tick     = (st != sIdle) & (qCnt == '0);	// End of a quarter
	assign lastQ    = tick & (phase == 2'd3) & ((st != sByte) | (bitCnt == 4'd8));

	// ------------------------------
	// Command FSM
	// ------------------------------
	always_ff @(posedge iSysClk)
	begin
		if (rst)
		begin
			st       <= sIdle;
			rspValid <= 1'b0;
		end
		else
		begin
			rspValid <= lastQ;
			if (accept)
			begin
				case (cmd.op)
					opStart:	st <= sStart;
					opStop:		st <= sStop;
					default:	st <= sByte;	// Write and read share the bit timing
				endcase
			end
			else if (lastQ)
				st <= sIdle;
		end
	end

	// Quarter, phase and bit counters
	always_ff @(posedge iSysClk)
	begin
		if (rst)
		begin
			qCnt   <= '0;
			phase  <= 2'd0;
			bitCnt <= 4'd0;
		end
		else if (accept)
		begin
			qCnt   <= div;
			phase  <= 2'd0;
			bitCnt <= 4'd0;
		end
		else if (tick)
		begin
			qCnt  <= divLatch;		// Reload
			phase <= phase + 2'd1;
			if (phase == 2'd3)
				bitCnt <= bitCnt + 4'd1;
		end
		else if (st != sIdle)
			qCnt <= qCnt - 1'b1;
	end

	// ------------------------------
	// Data path
	// ------------------------------
	always_ff @(posedge iSysClk)
	begin
		if (accept)
		begin
			divLatch <= div;
			isRead   <= (cmd.op == opRead);
			ackBit   <= cmd.ack;
			shift    <= cmd.data;
		end
		else if (tick && st == sByte)
		begin
			// Sample at the middle of SCL high; a line that never rose reads as 1
			if (phase == 2'd1)
			begin
				if (bitCnt == 4'd8)
					nackBit <= sdaIn | ~sclIn;
				else
					smpBit <= sdaIn | ~sclIn;
			end
			else if (phase == 2'd3 && bitCnt != 4'd8)
				shift <= {shift[6:0], smpBit};	// MSB out, sample in
		end
	end

	assign rsp = '{data: shift, nack: nackBit};

	// SDA drive for the current bit
	always_comb
	begin
		if (bitCnt == 4'd8)
			bitOe = isRead ? ~ackBit : 1'b0;	// Master ack or release for slave
		else
			bitOe = isRead ? 1'b0 : ~shift[7];
	end

	// ------------------------------
	// Pin levels per quarter
	// ------------------------------
	always_comb
	begin
		sclNext = sclOe;	// Idle holds the lines
		sdaNext = sdaOe;
		case (st)
			sStart:
			begin
				sdaNext = (phase >= 2'd2);		// SDA falls with SCL high
				if (phase != 2'd0)
					sclNext = (phase == 2'd3);
			end
			sStop:
			begin
				sclNext = (phase == 2'd0);
				sdaNext = (phase <= 2'd1);		// SDA rises with SCL high
			end
			sByte:
			begin
				sclNext = (phase == 2'd0) | (phase == 2'd3);	// High in quarters 1 and 2
				sdaNext = bitOe;
			end
			default:
			begin
			end
		endcase
	end

	always_ff @(posedge iSysClk)
	begin
		if (rst)
		begin
			sclOe <= 1'b0;		// Bus released
			sdaOe <= 1'b0;
		end
		else
		begin
			sclOe <= sclNext;
			sdaOe <= sdaNext;
		end
	end

endmodule

`default_nettype wire

/* source/i2cCsr.sv */
// Keypad poller register block
`timescale 1ns/1ps
`default_nettype none

module i2cCsr #(
	parameter logic [7:0]	pAdrsMap	= 8'h04,	// Compared with adrs[15:8]
	parameter int			pI2CDivClk	= 16
)(
	input  wire						iSysClk,
	input  wire						rst,
	input  wire i2cPkg::usiWr_t		usiWr,
	output i2cPkg::usiRd_t			usiRd,
	input  wire [15:0]				keyPad,		// From sequencer
	input  wire						seqComp,
	output logic					en,
	output logic [pI2CDivClk-1:0]	div
);
	import i2cPkg::*;

	logic			blockHit;
	logic [7:0]		offset;
	csrWord_t		wrWord;
	logic			wrCtrl;
	logic			wrDiv;
	logic [15:0]	keyPadSmp;
	logic			seqCompSmp;
	logic [31:0]	rdNext;
	logic [31:0]	rdReg;
	logic			rEdReg;

	// ------------------------------
	// Decode
	// ------------------------------
	assign blockHit = (usiWr.adrs[15:8] == pAdrsMap);
	assign offset   = usiWr.adrs[7:0];
	assign wrWord   = usiWr.wd;		// Same word, view picked by offset
	assign wrCtrl   = usiWr.wCke & blockHit & (offset == csrCtrl);
	assign wrDiv    = usiWr.wCke & blockHit & (offset == csrDiv);

	// Writable control registers
	always_ff @(posedge iSysClk)
	begin
		if (rst)
		begin
			en  <= 1'b0;
			div <= '1;		// Slowest clock out of reset
		end
		else
		begin
			if (wrCtrl)
				en <= wrWord.ctrl.en;
			if (wrDiv)
				div <= wrWord.div.div[pI2CDivClk-1:0];	// Upper bits dropped
		end
	end

	// Status sampled every cycle
	always_ff @(posedge iSysClk)
	begin
		if (rst)
			seqCompSmp <= 1'b0;
		else
			seqCompSmp <= seqComp;
	end

	always_ff @(posedge iSysClk)
		keyPadSmp <= keyPad;

	// ------------------------------
	// Read back
	// ------------------------------
	always_comb
	begin
		case (offset)
			csrCtrl:	rdNext = {31'd0, en};
			csrDiv:		rdNext = {{(32 - pI2CDivClk){1'b0}}, div};
			csrKeyPad:	rdNext = {16'd0, keyPadSmp};
			csrSeqComp:	rdNext = {31'd0, seqCompSmp};
			default:	rdNext = 32'd0;		// Unmapped reads as zero
		endcase
	end

	always_ff @(posedge iSysClk)
		rdReg <= rdNext;

	// Any block hit answers, writes included
	always_ff @(posedge iSysClk)
	begin
		if (rst)
			rEdReg <= 1'b0;
		else
			rEdReg <= blockHit;
	end

	assign usiRd = '{rd: rdReg, rEd: rEdReg};

endmodule

`default_nettype wire

/* source/i2cKeypadSeq.sv */
// Keypad polling sequencer
`timescale 1ns/1ps
`default_nettype none

module i2cKeypadSeq #(
	parameter logic [6:0]	pKeypadAdrs	= 7'h27
)(
	input  wire						iSysClk,
	input  wire						rst,
	input  wire						en,
	output i2cPkg::i2cCmd_t			cmd,
	output logic					cmdValid,
	input  wire						cmdReady,
	input  wire i2cPkg::i2cRsp_t	rsp,
	input  wire						rspValid,
	output logic [15:0]				keyPad,
	output logic					seqComp
);
	import i2cPkg::*;

	typedef enum logic [2:0] {sIdle, sStart, sAdrs, sRdHi, sRdLo, sStop} seqSt_t;

	seqSt_t			st;
	logic			waitRsp;	// Command taken, response pending
	logic			keyOk;		// Address acked this round
	logic [15:0]	keyAsm;
	logic			commit;

	assign cmdValid = (st != sIdle) & ~waitRsp;
	assign commit   = rspValid & (st == sStop) & keyOk;

	// Command per state, steady while waiting for ready
	always_comb
	begin
		cmd = '{op: opStart, data: 8'h00, ack: 1'b1};
		case (st)
			sAdrs:
			begin
				cmd.op   = opWrite;
				cmd.data = {pKeypadAdrs, 1'b1};	// Read bit
			end
			sRdHi:
			begin
				cmd.op  = opRead;
				cmd.ack = 1'b0;		// More to come
			end
			sRdLo:
				cmd.op = opRead;	// Last byte gets nack
			sStop:
				cmd.op = opStop;
			default:
			begin
			end
		endcase
	end

	// ------------------------------
	// Transaction FSM
	// ------------------------------
	always_ff @(posedge iSysClk)
	begin
		if (rst)
		begin
			st      <= sIdle;
			waitRsp <= 1'b0;
			keyOk   <= 1'b0;
		end
		else
		begin
			if (cmdValid && cmdReady)
				waitRsp <= 1'b1;
			else if (rspValid)
				waitRsp <= 1'b0;

			if (rspValid)
			begin
				case (st)
					sStart:	st <= sAdrs;
					sAdrs:
					begin
						keyOk <= ~rsp.nack;
						st    <= rsp.nack ? sStop : sRdHi;	// No slave, close out
					end
					sRdHi:	st <= sRdLo;
					sRdLo:	st <= sStop;
					sStop:	st <= en ? sStart : sIdle;		// Round ends on stop
					default: st <= sIdle;
				endcase
			end
			else if (st == sIdle && en)
				st <= sStart;
		end
	end

	// Byte assembly
	always_ff @(posedge iSysClk)
	begin
		if (rspValid && st == sRdHi)
			keyAsm[15:8] <= rsp.data;
		if (rspValid && st == sRdLo)
			keyAsm[7:0] <= rsp.data;
	end

	// Result and completion flag
	always_ff @(posedge iSysClk)
	begin
		if (rst)
		begin
			keyPad  <= 16'd0;
			seqComp <= 1'b0;
		end
		else
		begin
			if (commit)
				keyPad <= keyAsm;
			if (!en)
				seqComp <= 1'b0;
			else if (commit)
				seqComp <= 1'b1;
		end
	end

endmodule

`default_nettype wire

/* source/i2cKeypadTop.sv */
// I2C keypad poller top
`timescale 1ns/1ps
`default_nettype none

module i2cKeypadTop #(
	parameter logic [7:0]	pAdrsMap	= 8'h04,
	parameter int			pI2CDivClk	= 16,
	parameter logic [6:0]	pKeypadAdrs	= 7'h27
)(
	input  wire						iSysClk,
	input  wire						rst,
	input  wire i2cPkg::usiWr_t		usiWr,
	output i2cPkg::usiRd_t			usiRd,
	output logic					sclOe,
	output logic					sdaOe,
	input  wire						sclIn,
	input  wire						sdaIn
);
	import i2cPkg::*;

	// ------------------------------
	// Internal wiring
	// ------------------------------
	logic					en;
	logic [pI2CDivClk-1:0]	div;
	logic [15:0]			keyPad;
	logic					seqComp;
	i2cCmd_t				cmd;
	logic					cmdValid;
	logic					cmdReady;
	i2cRsp_t				rsp;
	logic					rspValid;

	i2cCsr #(
		.pAdrsMap	(pAdrsMap),
		.pI2CDivClk	(pI2CDivClk)
	) i_csr (
		.iSysClk	(iSysClk),
		.rst		(rst),
		.usiWr		(usiWr),
		.usiRd		(usiRd),
		.keyPad		(keyPad),
		.seqComp	(seqComp),
		.en			(en),
		.div		(div)
	);

	i2cKeypadSeq #(
		.pKeypadAdrs	(pKeypadAdrs)
	) i_seq (
		.iSysClk	(iSysClk),
		.rst		(rst),
		.en			(en),
		.cmd		(cmd),
		.cmdValid	(cmdValid),
		.cmdReady	(cmdReady),
		.rsp		(rsp),
		.rspValid	(rspValid),
		.keyPad		(keyPad),
		.seqComp	(seqComp)
	);

	i2cBitEngine #(
		.pI2CDivClk	(pI2CDivClk)
	) i_engine (
		.iSysClk	(iSysClk),
		.rst		(rst),
		.div		(div),
		.cmd		(cmd),
		.cmdValid	(cmdValid),
		.cmdReady	(cmdReady),
		.rsp		(rsp),
		.rspValid	(rspValid),
		.sclOe		(sclOe),
		.sdaOe		(sdaOe),
		.sclIn		(sclIn),
		.sdaIn		(sdaIn)
	);

endmodule

`default_nettype wire

/* source/i2cPkg.sv */
// Keypad poller shared types
`default_nettype none

package i2cPkg;

	// ------------------------------
	// Bus request and response
	// ------------------------------
	typedef struct packed {
		logic [31:0]	adrs;	// Block in 15:8, offset in 7:0
		logic [31:0]	wd;
		logic			wCke;	// One-cycle write strobe
	} usiWr_t;

	typedef struct packed {
		logic [31:0]	rd;
		logic			rEd;	// Read valid, one cycle after request
	} usiRd_t;

	// CSR write word, two ways of looking at wd
	typedef struct packed {
		logic [30:0]	rsvd;
		logic			en;
	} csrCtrlView_t;

	typedef struct packed {
		logic [15:0]	rsvd;
		logic [15:0]	div;
	} csrDivView_t;

	typedef union packed {
		csrCtrlView_t	ctrl;
		csrDivView_t	div;
	} csrWord_t;

	// ------------------------------
	// Sequencer to engine
	// ------------------------------
	typedef enum logic [1:0] {opStart, opStop, opWrite, opRead} i2cOp_t;

	typedef struct packed {
		i2cOp_t			op;
		logic [7:0]		data;	// Byte to send on opWrite
		logic			ack;	// Ninth bit driven on opRead, 0 = ACK
	} i2cCmd_t;

	typedef struct packed {
		logic [7:0]		data;	// Byte seen on the line
		logic			nack;	// Slave answer to a write
	} i2cRsp_t;

	// Register offsets
	localparam logic [7:0] csrCtrl    = 8'h00;
	localparam logic [7:0] csrDiv     = 8'h04;
	localparam logic [7:0] csrKeyPad  = 8'h80;
	localparam logic [7:0] csrSeqComp = 8'h84;

endpackage

`default_nettype wire
